// File: common/la_pkg.sv
package la_pkg;

    typedef logic [7:0]  byte_t;       // uart data byte
    typedef logic [7:0]  sample_t;     // one io sample
    typedef logic [7:0]  prescale_t;   // sample every prescale+1 clocks
    typedef logic [15:0] post_cnt_t;   // samples left after trigger

    // mask, polarity, prescale, post count in units of 256
    localparam int CMD_BYTES = 4;

    typedef enum logic {
        CAP_IDLE,
        CAP_RUNNING
    } cap_state_t;

    typedef enum logic [2:0] {
        ST_RECV,       // collecting command bytes
        ST_PROGRAM,    // load config, fire start
        ST_WAIT_CAP,   // busy up then down
        ST_PTR_LO,     // wptr[7:0]
        ST_PTR_HI,     // wptr[15:8]
        ST_SEND_BUF,   // buffer bytes 0 upward
        ST_BUF_WAIT    // first ram read in flight
    } ctrl_state_t;

endpackage

// File: common/capture_if.sv
`timescale 1ns/1ps

interface capture_if #(
    parameter int ADDR_W = 10
);

    la_pkg::sample_t   trig_mask;   // bits that take part in the trigger
    la_pkg::sample_t   trig_pol;    // wanted level of those bits
    la_pkg::prescale_t prescale;
    la_pkg::post_cnt_t post_cnt;
    logic              start;       // one-cycle pulse, idle engine only
    logic              busy;
    logic              triggered;
    logic [ADDR_W-1:0] wptr;        // valid while busy is low
    logic [ADDR_W-1:0] rd_addr;
    la_pkg::sample_t   rd_data;     // one cycle after rd_addr

    modport ctrl (
        output trig_mask, trig_pol, prescale, post_cnt, start, rd_addr,
        input  busy, triggered, wptr, rd_data
    );

    modport engine (
        input  trig_mask, trig_pol, prescale, post_cnt, start, rd_addr,
        output busy, triggered, wptr, rd_data
    );

endinterface

// File: uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
    parameter int BAUD_DIV = 234
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          rx_pin,
    input  logic          rx_read,
    output logic          rx_valid,
    output la_pkg::byte_t rx_byte
);

    localparam int CNT_W = $clog2(BAUD_DIV) + 1;

    logic [2:0]       rx_sync;      // [1] is the synced bit, [2] its last value
    logic             rx_bit;
    logic             start_edge;
    logic             busy;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_idx;      // 0 start, 1..8 data, 9 stop
    logic             sample_now;
    logic             data_bit;
    logic             byte_done;
    la_pkg::byte_t    shift;

    assign rx_bit     = rx_sync[1];
    assign start_edge = rx_sync[2] & ~rx_sync[1];
    assign sample_now = busy && (baud_cnt == '0);
    assign data_bit   = sample_now && (bit_idx >= 4'd1) && (bit_idx <= 4'd8);
    // stop bit must be high and the holding register free
    assign byte_done  = sample_now && (bit_idx == 4'd9) && rx_bit && (!rx_valid || rx_read);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sync  <= '1;            // line idles high
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], rx_pin};
            if (rx_read) begin
                rx_valid <= 1'b0;
            end
            if (!busy) begin
                if (start_edge) begin
                    busy     <= 1'b1;
                    baud_cnt <= CNT_W'(BAUD_DIV / 2 - 1);   // land mid start bit
                    bit_idx  <= '0;
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= CNT_W'(BAUD_DIV - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    if (rx_bit) begin
                        busy <= 1'b0;  // glitch, not a real start bit
                    end
                end else if (bit_idx == 4'd9) begin
                    busy <= 1'b0;
                    if (byte_done) begin
                        rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (data_bit) begin
            shift <= {rx_bit, shift[7:1]};     // lsb first
        end
        if (byte_done) begin
            rx_byte <= shift;
        end
    end

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
    parameter int BAUD_DIV   = 234,
    parameter int FIFO_DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          tx_push,
    input  la_pkg::byte_t tx_data,
    output logic          tx_full,
    output logic          tx_pin
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(BAUD_DIV) + 1;

    la_pkg::byte_t    fifo_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             fifo_empty;
    logic             push_ok;
    logic             pop;

    logic             busy;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bits_left;
    logic [9:0]       shift;        // stop, data, start
    logic             frame_end;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign tx_full    = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign push_ok    = tx_push && !tx_full;
    assign frame_end  = busy && (baud_cnt == '0) && (bits_left == 4'd1);
    assign pop        = !fifo_empty && (!busy || frame_end);   // back to back frames
    assign tx_pin     = shift[0];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            fifo_mem[wr_ptr] <= tx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            baud_cnt  <= '0;
            bits_left <= '0;
            shift     <= '1;           // idle line
        end else if (pop) begin
            busy      <= 1'b1;
            baud_cnt  <= CNT_W'(BAUD_DIV - 1);
            bits_left <= 4'd10;
            shift     <= {1'b1, fifo_mem[rd_ptr], 1'b0};
        end else if (busy) begin
            if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt  <= CNT_W'(BAUD_DIV - 1);
                shift     <= {1'b1, shift[9:1]};
                bits_left <= bits_left - 1'b1;
                if (bits_left == 4'd1) begin
                    busy <= 1'b0;      // stop bit done
                end
            end
        end
    end

endmodule

// File: capture/capture_engine.sv
`timescale 1ns/1ps

module capture_engine #(
    parameter int ADDR_W = 10
) (
    input  logic            clk,
    input  logic            rst_n,
    input  la_pkg::sample_t io,
    capture_if.engine       cap
);

    la_pkg::cap_state_t state;
    la_pkg::sample_t    io_q;           // io registered every cycle
    la_pkg::sample_t    prev_sample;    // last sample written
    la_pkg::sample_t    mask_q;
    la_pkg::sample_t    pol_q;
    la_pkg::prescale_t  presc_q;
    la_pkg::prescale_t  presc_cnt;
    la_pkg::post_cnt_t  post_cnt;
    logic [ADDR_W-1:0]  wr_ptr;
    logic               prev_valid;     // no trigger on the very first sample
    logic               triggered;
    logic               tick;
    logic               trig_event;

    la_pkg::sample_t ram [2**ADDR_W];

    assign tick = (state == la_pkg::CAP_RUNNING) && (presc_cnt == '0) && (post_cnt != '0);
    // a masked bit moved and a masked bit sits at its polarity
    assign trig_event = tick && prev_valid
                      && (|((io_q ^ prev_sample) & mask_q))
                      && (|(~(io_q ^ pol_q) & mask_q));

    assign cap.busy      = (state == la_pkg::CAP_RUNNING);
    assign cap.triggered = triggered;

    always_ff @(posedge clk) begin
        if (tick) begin
            ram[wr_ptr] <= io_q;
        end
        cap.rd_data <= ram[cap.rd_addr];
    end

    always_ff @(posedge clk) begin
        io_q <= io;
        if (tick) begin
            prev_sample <= io_q;
        end
        if (cap.start && state == la_pkg::CAP_IDLE) begin
            mask_q  <= cap.trig_mask;
            pol_q   <= cap.trig_pol;
            presc_q <= cap.prescale;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= la_pkg::CAP_IDLE;
            presc_cnt  <= '0;
            post_cnt   <= '0;
            wr_ptr     <= '0;
            prev_valid <= 1'b0;
            triggered  <= 1'b0;
            cap.wptr   <= '0;
        end else begin
            case (state)
                la_pkg::CAP_IDLE: begin
                    if (cap.start) begin
                        state      <= la_pkg::CAP_RUNNING;
                        presc_cnt  <= '0;      // tick on the first running cycle
                        post_cnt   <= cap.post_cnt;
                        wr_ptr     <= '0;
                        prev_valid <= 1'b0;
                        triggered  <= 1'b0;
                    end
                end
                la_pkg::CAP_RUNNING: begin
                    if (post_cnt == '0) begin
                        state    <= la_pkg::CAP_IDLE;
                        cap.wptr <= wr_ptr;    // next address after last write
                    end else if (tick) begin
                        presc_cnt  <= presc_q;
                        wr_ptr     <= wr_ptr + 1'b1;   // wraps at buffer depth
                        prev_valid <= 1'b1;
                        if (trig_event) begin
                            triggered <= 1'b1;
                        end
                        if (trig_event || triggered) begin
                            post_cnt <= post_cnt - 1'b1;
                        end
                    end else begin
                        presc_cnt <= presc_cnt - 1'b1;
                    end
                end
                default: state <= la_pkg::CAP_IDLE;
            endcase
        end
    end

endmodule

// File: hw/la_controller.sv
`timescale 1ns/1ps

module la_controller #(
    parameter int ADDR_W = 10
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          rx_valid,
    input  la_pkg::byte_t rx_byte,
    output logic          rx_read,
    input  logic          tx_full,
    output logic          tx_push,
    output la_pkg::byte_t tx_data,
    capture_if.ctrl       cap,
    output logic [3:0]    led
);

    localparam int CNT_W = $clog2(la_pkg::CMD_BYTES);

    la_pkg::ctrl_state_t state;
    la_pkg::byte_t       frame [la_pkg::CMD_BYTES];
    logic [CNT_W-1:0]    byte_cnt;
    logic                cap_seen;      // busy has been high since start
    logic [ADDR_W-1:0]   buf_addr;
    logic [15:0]         wptr_ext;
    logic                dumping;

    assign wptr_ext = 16'(cap.wptr);
    assign rx_read  = (state == la_pkg::ST_RECV) && rx_valid;
    assign dumping  = state inside {la_pkg::ST_PTR_LO, la_pkg::ST_PTR_HI,
                                    la_pkg::ST_BUF_WAIT, la_pkg::ST_SEND_BUF};

    // look one address ahead whenever a buffer byte goes out
    assign cap.rd_addr = (state == la_pkg::ST_SEND_BUF && !tx_full) ? buf_addr + 1'b1
                                                                     : buf_addr;

    always_comb begin
        tx_push = 1'b0;
        tx_data = '0;
        case (state)
            la_pkg::ST_PTR_LO: begin
                tx_push = !tx_full;
                tx_data = wptr_ext[7:0];
            end
            la_pkg::ST_PTR_HI: begin
                tx_push = !tx_full;
                tx_data = wptr_ext[15:8];
            end
            la_pkg::ST_SEND_BUF: begin
                tx_push = !tx_full;
                tx_data = cap.rd_data;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rx_read) begin
            frame[byte_cnt] <= rx_byte;
        end
        if (state == la_pkg::ST_PROGRAM) begin
            cap.trig_mask <= frame[0];
            cap.trig_pol  <= frame[1];
            cap.prescale  <= frame[2];
            cap.post_cnt  <= {frame[3], 8'h00};     // units of 256 samples
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= la_pkg::ST_RECV;
            byte_cnt  <= '0;
            cap.start <= 1'b0;
            cap_seen  <= 1'b0;
            buf_addr  <= '0;
            led       <= 4'hF;         // active low, all off
        end else begin
            cap.start <= (state == la_pkg::ST_PROGRAM);
            led       <= {1'b1, ~dumping, ~cap.triggered, ~cap.busy};
            case (state)
                la_pkg::ST_RECV: begin
                    if (rx_read) begin
                        if (byte_cnt == CNT_W'(la_pkg::CMD_BYTES - 1)) begin
                            byte_cnt <= '0;
                            state    <= la_pkg::ST_PROGRAM;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                la_pkg::ST_PROGRAM: begin
                    cap_seen <= 1'b0;
                    state    <= la_pkg::ST_WAIT_CAP;
                end
                la_pkg::ST_WAIT_CAP: begin
                    if (cap.busy) begin
                        cap_seen <= 1'b1;
                    end else if (cap_seen) begin
                        buf_addr <= '0;
                        state    <= la_pkg::ST_PTR_LO;
                    end
                end
                la_pkg::ST_PTR_LO: begin
                    if (!tx_full) begin
                        state <= la_pkg::ST_PTR_HI;
                    end
                end
                la_pkg::ST_PTR_HI: begin
                    if (!tx_full) begin
                        state <= la_pkg::ST_BUF_WAIT;
                    end
                end
                la_pkg::ST_BUF_WAIT: begin
                    state <= la_pkg::ST_SEND_BUF;  // rd_data for addr 0 next cycle
                end
                la_pkg::ST_SEND_BUF: begin
                    if (!tx_full) begin
                        buf_addr <= buf_addr + 1'b1;
                        if (&buf_addr) begin
                            state <= la_pkg::ST_RECV;      // whole buffer sent
                        end
                    end
                end
                default: state <= la_pkg::ST_RECV;
            endcase
        end
    end

endmodule

// File: hw/la_top.sv
`timescale 1ns/1ps

module la_top #(
    parameter int BAUD_DIV   = 234,    // 27 MHz / 115200
    parameter int ADDR_W     = 10,
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    input  logic [7:0] io,
    output logic       uart_tx,
    output logic [3:0] led
);

    logic          rx_valid;
    logic          rx_read;
    la_pkg::byte_t rx_byte;
    logic          tx_push;
    logic          tx_full;
    la_pkg::byte_t tx_data;

    capture_if #(.ADDR_W(ADDR_W)) cap_bus ();

    uart_rx #(.BAUD_DIV(BAUD_DIV)) u_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_pin   (uart_rx),
        .rx_read  (rx_read),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    uart_tx #(.BAUD_DIV(BAUD_DIV), .FIFO_DEPTH(FIFO_DEPTH)) u_uart_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_push (tx_push),
        .tx_data (tx_data),
        .tx_full (tx_full),
        .tx_pin  (uart_tx)
    );

    la_controller #(.ADDR_W(ADDR_W)) u_la_controller (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .rx_read  (rx_read),
        .tx_full  (tx_full),
        .tx_push  (tx_push),
        .tx_data  (tx_data),
        .cap      (cap_bus),
        .led      (led)
    );

    capture_engine #(.ADDR_W(ADDR_W)) u_capture_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .io    (io),
        .cap   (cap_bus)
    );

endmodule

// File: testbench/tb_la_model.svh
`ifndef TB_LA_MODEL_SVH
`define TB_LA_MODEL_SVH

// one 8N1 frame on the host line, lsb first
task automatic uart_send_byte(input la_pkg::byte_t b);
    int i;
    uart_in = 1'b0;                        // start bit
    repeat (BAUD_DIV) @(negedge clk);
    for (i = 0; i < 8; i++) begin
        uart_in = b[i];
        repeat (BAUD_DIV) @(negedge clk);
    end
    uart_in = 1'b1;                        // stop bit
    repeat (BAUD_DIV) @(negedge clk);
endtask

// Checks one dump against the capture rules and returns the error count.
// The post-trigger window is post*256 samples ending just below the pointer.
function automatic int dump_errors(input la_pkg::byte_t dump [$],
                                   input la_pkg::byte_t mask,
                                   input la_pkg::byte_t pol,
                                   input la_pkg::prescale_t presc,
                                   input la_pkg::byte_t post,
                                   output la_pkg::byte_t first_s,
                                   output la_pkg::byte_t prev_s);
    int n;
    int i;
    int wptr;
    int span;
    int first;
    int addr;
    int bit_i;
    logic moved;
    logic at_pol;
    la_pkg::byte_t cur;
    la_pkg::byte_t prev;
    la_pkg::byte_t step;
    n = 0;
    first_s = 'x;
    prev_s = 'x;
    if (dump.size() != DUMP_LEN) begin
        $display("error %0t: dump holds %0d bytes, expected %0d", $time, dump.size(), DUMP_LEN);
        return 1;
    end
    if ($isunknown({dump[1], dump[0]})) begin
        $display("error %0t: pointer bytes are unknown", $time);
        return 1;
    end
    wptr = {dump[1], dump[0]};
    if (wptr >= DEPTH) begin
        $display("error %0t: pointer %0d is outside the buffer", $time, wptr);
        return 1;
    end
    span = post * 256;
    step = presc + 8'd1;
    first = ((wptr - span) % DEPTH + DEPTH) % DEPTH;
    for (i = 0; i < span; i++) begin
        addr = (first + i) % DEPTH;
        cur = dump[2 + addr];
        prev = dump[2 + (addr + DEPTH - 1) % DEPTH];
        if (i == 0) begin
            first_s = cur;
            prev_s = prev;
            moved = 1'b0;
            at_pol = 1'b0;
            for (bit_i = 0; bit_i < 8; bit_i++) begin
                if (mask[bit_i] && cur[bit_i] !== prev[bit_i]) begin
                    moved = 1'b1;          // a watched bit changed
                end
                if (mask[bit_i] && cur[bit_i] === pol[bit_i]) begin
                    at_pol = 1'b1;         // a watched bit at its level
                end
            end
            if (!(moved && at_pol)) begin
                $display("error %0t: sample %h at %0d after %h is no trigger event",
                         $time, cur, addr, prev);
                n++;
            end
        end else if (cur !== la_pkg::byte_t'(prev + step)) begin
            if (n < 10) begin
                $display("error %0t: sample at %0d is %h, expected %h",
                         $time, addr, cur, la_pkg::byte_t'(prev + step));
            end
            n++;
        end
    end
    return n;
endfunction

`endif

// File: testbench/tb_la_top.sv
`timescale 1ns/1ps

module tb_la_top;

    localparam int BAUD_DIV       = 8;
    localparam int ADDR_W         = 10;
    localparam int DEPTH          = 1 << ADDR_W;
    localparam int DUMP_LEN       = DEPTH + 2;     // pointer bytes plus buffer
    localparam int TIMEOUT_CYCLES = 400000;
    localparam int IDLE_END       = 200;           // quiet line after a dump

    logic          clk;
    logic          rst_n;
    logic          uart_in;
    logic [7:0]    io;
    logic          uart_out;
    logic [3:0]    led;

    la_pkg::byte_t got_q [$];                      // bytes decoded from uart_out
    int            errors;
    int            frame_errs;
    int            cycles;
    logic          seen_run;
    logic          seen_trig;
    logic          seen_dump;

    `include "tb_la_model.svh"

    la_top #(
        .BAUD_DIV (BAUD_DIV),
        .ADDR_W   (ADDR_W)
    ) u_la_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .uart_rx (uart_in),
        .io      (io),
        .uart_tx (uart_out),
        .led     (led)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(negedge clk) begin
        io <= io + 8'd1;                           // free running pattern
        if (led[0] === 1'b0) seen_run = 1'b1;
        if (led[1] === 1'b0) seen_trig = 1'b1;
        if (led[2] === 1'b0) seen_dump = 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // host receiver, samples mid-bit
    initial begin : uart_monitor
        la_pkg::byte_t b;
        int k;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && uart_out === 1'b0) begin
                repeat (BAUD_DIV / 2 - 1) @(negedge clk);
                if (uart_out !== 1'b0) begin
                    $display("framing failure at %0t: start bit did not hold low", $time);
                    frame_errs++;
                end
                for (k = 0; k < 8; k++) begin
                    repeat (BAUD_DIV) @(negedge clk);
                    b[k] = uart_out;
                end
                repeat (BAUD_DIV) @(negedge clk);
                if (uart_out !== 1'b1) begin
                    $display("framing failure at %0t: stop bit was not high", $time);
                    frame_errs++;
                end
                got_q.push_back(b);
            end
        end
    end

    task automatic wait_dump_end();
        int idle;
        idle = 0;
        while (!(got_q.size() > 0 && idle >= IDLE_END)) begin
            @(negedge clk);
            if (uart_out === 1'b1) idle++;
            else idle = 0;
        end
    endtask

    task automatic run_test(input la_pkg::byte_t mask, input la_pkg::byte_t pol,
                            input la_pkg::prescale_t presc, input la_pkg::byte_t post,
                            output la_pkg::byte_t first_s, output la_pkg::byte_t prev_s);
        la_pkg::byte_t dump_q [$];
        int n;
        got_q.delete();
        seen_run = 1'b0;
        seen_trig = 1'b0;
        seen_dump = 1'b0;
        uart_send_byte(mask);                      // command frame, mask first
        uart_send_byte(pol);
        uart_send_byte(presc);
        uart_send_byte(post);
        wait_dump_end();
        dump_q = got_q;
        n = dump_errors(dump_q, mask, pol, presc, post, first_s, prev_s);
        if (n != 0) errors += n;
    endtask

    initial begin : test_seq
        int unsigned rnd;
        la_pkg::prescale_t presc_rand;
        la_pkg::byte_t first_s;
        la_pkg::byte_t prev_s;
        logic quiet_bad;
        rnd = $urandom(68);
        presc_rand = la_pkg::prescale_t'(1 + rnd % 7);
        errors = 0;
        frame_errs = 0;
        cycles = 0;
        quiet_bad = 1'b0;
        seen_run = 1'b0;
        seen_trig = 1'b0;
        seen_dump = 1'b0;
        rst_n = 1'b0;
        uart_in = 1'b1;
        io = 8'h00;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // idle after reset
        repeat (300) begin
            @(negedge clk);
            if (uart_out !== 1'b1 || led !== 4'hF) quiet_bad = 1'b1;
        end
        if (quiet_bad) begin
            errors++;
            $display("error %0t: uart_tx or led left idle before any command", $time);
        end
        if (got_q.size() != 0) begin
            errors++;
            $display("error %0t: %0d bytes came out before any command", $time, got_q.size());
        end

        // rising edge on bit 7, no prescale
        run_test(8'h80, 8'h80, 8'd0, 8'd1, first_s, prev_s);
        if (first_s !== 8'h80 || prev_s !== 8'h7F) begin
            errors++;
            $display("error %0t: trigger pair is %h after %h, expected 80 after 7f",
                     $time, first_s, prev_s);
        end
        if (!seen_run) begin
            errors++;
            $display("error %0t: led bit 0 never went low during capture", $time);
        end
        if (!seen_trig) begin
            errors++;
            $display("error %0t: led bit 1 never went low after the trigger", $time);
        end
        if (!seen_dump) begin
            errors++;
            $display("error %0t: led bit 2 never went low during dump", $time);
        end

        // falling edge on bit 7, random prescale
        run_test(8'h80, 8'h00, presc_rand, 8'd1, first_s, prev_s);
        if (first_s[7] !== 1'b0 || prev_s[7] !== 1'b1) begin
            errors++;
            $display("error %0t: trigger pair %h after %h is not a falling bit 7",
                     $time, first_s, prev_s);
        end

        // back to back command, two units of post count
        run_test(8'h80, 8'h80, 8'd0, 8'd2, first_s, prev_s);

        $display("checks failed: %0d, framing failures: %0d", errors, frame_errs);
        if (errors == 0 && frame_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+testbench
common/la_pkg.sv
common/capture_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
capture/capture_engine.sv
hw/la_controller.sv
hw/la_top.sv
testbench/tb_la_top.sv

// File: Bender.yml
package:
  name: la_top

sources:
  - files:
      - common/la_pkg.sv
      - common/capture_if.sv
      - uart/uart_rx.sv
      - uart/uart_tx.sv
      - capture/capture_engine.sv
      - hw/la_controller.sv
      - hw/la_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_la_top.sv
